// ==== rtl/ifetch_macros.svh ====
`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

// data path width, also the instruction word width
`define IFETCH_XLEN 32

// sequential step between instruction words
`define IFETCH_PC_STEP 32'd4

// first fetch address once reset is released
`define IFETCH_RESET_PC 32'h0400_0000

// target of an interrupt redirect
`define IFETCH_INT_VECTOR 32'h0400_0020

// handed to the pipeline while the memory stalls (sll-free special, func 0x21)
`define IFETCH_NOP 32'h0000_0021

// predictor index bits, taken from the pc starting at bit 2
`define IFETCH_PT_ABITS 12
`define IFETCH_PT_DEPTH (1 << `IFETCH_PT_ABITS)

`endif

// ==== rtl/ifetch_pkg.sv ====
`include "ifetch_macros.svh"

package ifetch_pkg;

  // register format: alu ops, jr/jalr
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] func;
  } r_fmt_t;

  // immediate format: loads, stores, conditional branches
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] offset;
  } i_fmt_t;

  // jump format
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] instr_index;
  } j_fmt_t;

  // one fetched word, three decodings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } instr_word_u;

  typedef struct packed {
    logic [`IFETCH_XLEN-1:0] address;  // always the next pc
    logic                    en;
    logic                    squashn;  // low kills the outstanding fetch
  } bus_req_t;

  typedef struct packed {
    logic [`IFETCH_XLEN-1:0] readdata;
    logic                    stall;    // memory busy, hold the address
    logic [`IFETCH_XLEN-1:0] ecause;
  } bus_rsp_t;

  typedef struct packed {
    logic                    en;       // early prediction point
    logic                    uncond;   // unconditional, always taken
    logic [`IFETCH_XLEN-1:0] tgt_pc;
  } predict_req_t;

  typedef struct packed {
    logic                    rdy;      // branch outcome known
    logic                    load;
    logic                    op;       // 1 unconditional pc write
    logic                    we;       // later stage pc write enable
    logic [`IFETCH_XLEN-1:0] data;     // jump / branch target
  } resolve_t;

endpackage

// ==== rtl/predict_table.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

// one bit per entry: 1 taken, 0 not taken
module predict_table (
  input  logic                    clk,
  input  logic [`IFETCH_XLEN-1:0] rd_addr,   // pc to predict for
  output logic                    taken,     // valid one cycle after rd_addr
  input  logic                    wr_en,
  input  logic [`IFETCH_XLEN-1:0] wr_addr,   // pc of the resolved branch
  input  logic                    wr_taken
);

  logic                        pt_mem [`IFETCH_PT_DEPTH];
  logic [`IFETCH_XLEN-1:0]     rd_pc_aligned;
  logic [`IFETCH_XLEN-1:0]     wr_pc_aligned;
  logic [`IFETCH_PT_ABITS-1:0] rd_idx;
  logic [`IFETCH_PT_ABITS-1:0] wr_idx;

  // branches never sit back to back (delay slot), so pc bit 2 is dropped
  assign rd_pc_aligned = {rd_addr[`IFETCH_XLEN-1:3], 3'b000};
  assign wr_pc_aligned = {wr_addr[`IFETCH_XLEN-1:3], 3'b000};
  assign rd_idx = rd_pc_aligned[`IFETCH_PT_ABITS+1:2];
  assign wr_idx = wr_pc_aligned[`IFETCH_PT_ABITS+1:2];

  // every entry starts out not taken
  initial
  begin
    for (int i = 0; i < `IFETCH_PT_DEPTH; i++)
    begin
      pt_mem[i] = 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      pt_mem[wr_idx] <= wr_taken;  // lands on the next edge
    end
    taken <= pt_mem[rd_idx];       // same-entry collision reads old data
  end

endmodule

// ==== rtl/pc_sequencer.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module pc_sequencer
  import ifetch_pkg::*;
(
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    en,              // fetch enable
  input  logic                    squashn,
  input  logic                    interrupt,
  input  logic                    stall,           // memory busy
  input  predict_req_t            predict,
  input  resolve_t                resolve,
  input  logic                    taken_lookup,    // table answer for the current pc
  input  logic                    is_delayslot,
  output logic [`IFETCH_XLEN-1:0] pc,
  output logic [`IFETCH_XLEN-1:0] next_pc,
  output logic [`IFETCH_XLEN-1:0] pc_plus4,
  output logic                    train_en,
  output logic [`IFETCH_XLEN-1:0] train_pc,
  output logic                    train_taken,
  output logic                    predict_result,  // low flushes the pipeline
  output logic                    bus_en
);

  logic                    pc_advance;
  logic                    ctrl_load;
  logic                    prediction;
  logic                    mispredict;
  logic                    rollback_en;
  logic [`IFETCH_XLEN-1:0] pc_rollback;       // path not chosen at prediction
  logic [`IFETCH_XLEN-1:0] pc_rollback_nt;    // pc of the predicted branch
  logic                    prediction_saved;
  logic                    predict_en_saved;  // conditional prediction in flight
  logic [`IFETCH_XLEN-1:0] pc_save_data;
  logic                    pc_save;
  logic                    squash_save;
  logic [`IFETCH_XLEN-1:0] sel_pc;
  logic                    pc_load_en;

  assign pc_advance = en & ~stall;
  assign ctrl_load  = resolve.op | resolve.load;
  assign prediction = predict.uncond | taken_lookup;  // unconditional is always taken
  assign pc_plus4   = pc + `IFETCH_PC_STEP;
  assign bus_en     = (en | ~squashn) & resetn;

  // outcome known and it differs from what was guessed
  assign mispredict = resolve.rdy & (ctrl_load != prediction_saved) & predict_en_saved;

  // rollback state, captured at the prediction point
  assign rollback_en = en & predict.en;

  always_ff @(posedge clk)
  begin
    if (rollback_en)
    begin
      pc_rollback    <= prediction ? pc_plus4 : predict.tgt_pc;
      pc_rollback_nt <= pc;
    end
  end

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      prediction_saved <= 1'b0;
      predict_en_saved <= 1'b0;
    end
    else if (rollback_en)
    begin
      prediction_saved <= prediction;
      predict_en_saved <= ~predict.uncond;  // only conditionals get checked
    end
  end

  // table training from the resolved outcome
  assign train_en    = resolve.rdy & predict_en_saved;
  assign train_pc    = pc_rollback_nt;
  assign train_taken = ctrl_load;

  // next pc, highest priority first
  always_comb
  begin
    if (interrupt)
    begin
      sel_pc     = `IFETCH_INT_VECTOR;
      pc_load_en = 1'b1;
    end
    else if (ctrl_load && !resolve.rdy)
    begin
      sel_pc     = resolve.data;   // indirect / unpredicted jump
      pc_load_en = 1'b1;
    end
    else if (predict.en && prediction)
    begin
      sel_pc     = predict.tgt_pc; // early taken guess
      pc_load_en = en;
    end
    else if (mispredict)
    begin
      sel_pc     = pc_rollback;
      pc_load_en = 1'b1;
    end
    else if (pc_save)
    begin
      sel_pc     = pc_save_data;   // write held over from a stall
      pc_load_en = pc_advance;
    end
    else
    begin
      sel_pc     = pc_plus4;
      pc_load_en = 1'b0;
    end
  end

  assign next_pc = pc_advance ? sel_pc : pc;

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      pc <= `IFETCH_RESET_PC;
    end
    else if (pc_advance)
    begin
      pc <= sel_pc;
    end
  end

  // pc writes arriving while stalled are parked until the next advance
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      pc_save     <= 1'b0;
      squash_save <= 1'b0;
    end
    else
    begin
      if (pc_load_en || pc_advance)
      begin
        pc_save <= pc_load_en & ~pc_advance;  // cleared once applied
      end
      if (!squashn || pc_advance)
      begin
        squash_save <= ~squashn & ~pc_advance;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (pc_load_en)
    begin
      pc_save_data <= sel_pc;
    end
  end

  // flush request, held off while the later stage owns the write
  always_comb
  begin
    if (ctrl_load && !resolve.rdy)
    begin
      predict_result = ~resolve.we;
    end
    else if (mispredict)
    begin
      predict_result = ~resolve.we;
    end
    else if (pc_save)
    begin
      predict_result = ~(squash_save & ~is_delayslot);  // keep the delay slot alive
    end
    else
    begin
      predict_result = 1'b1;
    end
  end

endmodule

// ==== rtl/instr_stage.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module instr_stage
  import ifetch_pkg::*;
(
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    advance,       // pc moves this edge
  input  logic [`IFETCH_XLEN-1:0] pc,
  input  bus_rsp_t                rsp,
  output instr_word_u             instr,
  output logic                    is_delayslot,  // current word follows a branch
  output logic [`IFETCH_XLEN-1:0] epc,
  output logic [`IFETCH_XLEN-1:0] ecause
);

  logic [5:0] opcode;
  logic [5:0] func;
  logic       is_special;
  logic       is_branch;

  // the following stage never stalls, so a nop is enough to cover the wait
  assign instr = rsp.stall ? `IFETCH_NOP : rsp.readdata;

  assign opcode = instr.r_fmt.opcode;
  assign func   = instr.r_fmt.func;

  // opcode 0 is the special group, jr/jalr sit at func 0x08/0x09
  assign is_special = (opcode == 6'd0);
  assign is_branch  = ((opcode[5:3] == 3'b000) && !is_special) ||
                      (is_special && (func[5:3] == 3'b001));

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      is_delayslot <= 1'b0;
    end
    else if (advance)
    begin
      is_delayslot <= is_branch;
    end
  end

  // exception in a delay slot restarts at the branch
  assign epc    = is_delayslot ? pc - `IFETCH_PC_STEP : pc;
  assign ecause = rsp.ecause;

endmodule

// ==== rtl/ifetch_top.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module ifetch_top
  import ifetch_pkg::*;
(
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    en,
  input  logic                    squashn,
  input  logic                    interrupt,
  input  predict_req_t            predict,
  input  resolve_t                resolve,
  output bus_req_t                bus_req,
  input  bus_rsp_t                bus_rsp,
  output instr_word_u             instr,
  output logic [`IFETCH_XLEN-1:0] pc_out,          // pc + 4
  output logic [`IFETCH_XLEN-1:0] epc,
  output logic [`IFETCH_XLEN-1:0] ecause,
  output logic                    predict_result
);

  logic [`IFETCH_XLEN-1:0] pc;
  logic [`IFETCH_XLEN-1:0] next_pc;
  logic                    taken;          // table lookup, one cycle late
  logic                    train_en;
  logic [`IFETCH_XLEN-1:0] train_pc;
  logic                    train_taken;
  logic                    is_delayslot;
  logic                    bus_en;
  logic                    advance;

  assign advance = en & ~bus_rsp.stall;

  // memory answers next_pc combinationally
  assign bus_req.address = next_pc;
  assign bus_req.en      = bus_en;
  assign bus_req.squashn = squashn;

  pc_sequencer pc_sequencer_inst (
    .clk            (clk),
    .resetn         (resetn),
    .en             (en),
    .squashn        (squashn),
    .interrupt      (interrupt),
    .stall          (bus_rsp.stall),
    .predict        (predict),
    .resolve        (resolve),
    .taken_lookup   (taken),
    .is_delayslot   (is_delayslot),
    .pc             (pc),
    .next_pc        (next_pc),
    .pc_plus4       (pc_out),
    .train_en       (train_en),
    .train_pc       (train_pc),
    .train_taken    (train_taken),
    .predict_result (predict_result),
    .bus_en         (bus_en)
  );

  // read issued for next_pc, answer lines up with pc on the next cycle
  predict_table predict_table_inst (
    .clk      (clk),
    .rd_addr  (next_pc),
    .taken    (taken),
    .wr_en    (train_en),
    .wr_addr  (train_pc),
    .wr_taken (train_taken)
  );

  instr_stage instr_stage_inst (
    .clk          (clk),
    .resetn       (resetn),
    .advance      (advance),
    .pc           (pc),
    .rsp          (bus_rsp),
    .instr        (instr),
    .is_delayslot (is_delayslot),
    .epc          (epc),
    .ecause       (ecause)
  );

endmodule

// ==== dv/ifetch_tb.sv ====
`timescale 1ns/1ps
`include "ifetch_macros.svh"

module ifetch_tb
  import ifetch_pkg::*;
();

  localparam int IMG_WORDS = 24;  // image covers 0x0400_0000 .. 0x0400_005c
  localparam int REC_BASE  = 24;  // first record word, @18 in the data file
  localparam int REC_WORDS = 6;   // ctrl stall data addr instr pr
  localparam int MAX_REC   = 64;
  localparam int PAT_WORDS = REC_BASE + REC_WORDS * (MAX_REC + 1);

  logic                    clk;
  logic                    resetn;
  logic                    en;
  logic                    squashn;
  logic                    interrupt;
  predict_req_t            predict;
  resolve_t                resolve;
  bus_req_t                bus_req;
  bus_rsp_t                bus_rsp;
  instr_word_u             instr;
  logic [`IFETCH_XLEN-1:0] pc_out;
  logic [`IFETCH_XLEN-1:0] epc;
  logic [`IFETCH_XLEN-1:0] ecause;
  logic                    predict_result;

  logic                    mem_stall;
  logic [`IFETCH_XLEN-1:0] mem_ecause;
  logic [`IFETCH_XLEN-1:0] mem_offset;
  logic [`IFETCH_XLEN-1:0] mem_word;
  logic [`IFETCH_XLEN-1:0] pat [PAT_WORDS];  // image then records

  logic [`IFETCH_XLEN-1:0] exp_pc;     // model of the pc register
  logic                    exp_delay;  // model of the delay-slot flag
  int                      n_rec;
  int                      cycle_count;
  int                      cycle_limit;
  int                      error_count;
  int unsigned             seed_val;

  always #10 clk = ~clk;  // 20 ns period

  // memory model, answers in the same cycle
  assign mem_offset = bus_req.address - `IFETCH_RESET_PC;
  assign mem_word   = (mem_offset < IMG_WORDS * 4) ? pat[mem_offset >> 2] : ~bus_req.address;
  assign bus_rsp    = {mem_word, mem_stall, mem_ecause};

  ifetch_top ifetch_top_inst (
    .clk            (clk),
    .resetn         (resetn),
    .en             (en),
    .squashn        (squashn),
    .interrupt      (interrupt),
    .predict        (predict),
    .resolve        (resolve),
    .bus_req        (bus_req),
    .bus_rsp        (bus_rsp),
    .instr          (instr),
    .pc_out         (pc_out),
    .epc            (epc),
    .ecause         (ecause),
    .predict_result (predict_result)
  );

  // branch rule: opcode 1..7, or special with func 0x08..0x0f
  function automatic logic branch_word(input logic [`IFETCH_XLEN-1:0] w);
    logic [5:0] op;
    logic [5:0] fn;
    op = w[31:26];
    fn = w[5:0];
    return ((op[5:3] == 3'b000) && (op != 6'd0)) || ((op == 6'd0) && (fn[5:3] == 3'b001));
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_addr(input string what, input logic [`IFETCH_XLEN-1:0] got,
                            input logic [`IFETCH_XLEN-1:0] exp);
    if (got !== exp)
    begin
      error_count++;
      abort_run($sformatf("Fail %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      error_count++;
      abort_run($sformatf("Fail %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // every view of the union against fields cut from the expected word
  task automatic check_instr(input string what, input instr_word_u got,
                             input logic [`IFETCH_XLEN-1:0] exp);
    logic bad_r;
    logic bad_i;
    logic bad_j;
    bad_r = got.r_fmt.opcode !== exp[31:26] || got.r_fmt.rs !== exp[25:21] ||
            got.r_fmt.rt !== exp[20:16] || got.r_fmt.rd !== exp[15:11] ||
            got.r_fmt.sa !== exp[10:6] || got.r_fmt.func !== exp[5:0];
    bad_i = got.i_fmt.opcode !== exp[31:26] || got.i_fmt.rs !== exp[25:21] ||
            got.i_fmt.rt !== exp[20:16] || got.i_fmt.offset !== exp[15:0];
    bad_j = got.j_fmt.opcode !== exp[31:26] || got.j_fmt.instr_index !== exp[25:0];
    if (bad_r || bad_i || bad_j)
    begin
      error_count++;
      abort_run($sformatf("Fail %0t: %s is %h, expected %h (r %b i %b j %b)",
                          $time, what, got, exp, bad_r, bad_i, bad_j));
    end
  endtask

  // one cycle with the memory busy, nothing else requested
  task automatic run_stall_cycle();
    @(posedge clk);
    en         <= 1'b1;
    squashn    <= 1'b0;  // kill the outstanding fetch while waiting
    interrupt  <= 1'b0;
    predict    <= '0;
    resolve    <= '0;
    mem_stall  <= 1'b1;
    mem_ecause <= $urandom;
    @(negedge clk);
    check_addr("address during stall", bus_req.address, exp_pc);  // holds
    check_instr("instr during stall", instr, `IFETCH_NOP);
    check_addr("pc_out during stall", pc_out, exp_pc + 4);
    check_flag("bus_req.squashn during stall", bus_req.squashn, 1'b0);
  endtask

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
    begin
      abort_run($sformatf("run timed out after %0d cycles", cycle_count));
    end
  end

  initial
  begin
    int                      base;
    logic [`IFETCH_XLEN-1:0] ctrl;
    logic [`IFETCH_XLEN-1:0] stall_mode;
    logic [`IFETCH_XLEN-1:0] data;
    logic [`IFETCH_XLEN-1:0] exp_addr;
    logic [`IFETCH_XLEN-1:0] exp_word;
    logic [`IFETCH_XLEN-1:0] exp_pr;
    seed_val    = $urandom(23562);
    clk         = 1'b0;
    resetn      = 1'b0;
    en          = 1'b0;
    squashn     = 1'b1;
    interrupt   = 1'b0;
    predict     = '0;
    resolve     = '0;
    mem_stall   = 1'b0;
    mem_ecause  = '0;
    cycle_count = 0;
    error_count = 0;
    cycle_limit = 50;
    $readmemh("dv/ifetch_patterns.txt", pat);
    n_rec = 0;
    while (n_rec < MAX_REC && pat[REC_BASE + REC_WORDS * n_rec] !== 32'hffff_ffff)
    begin
      n_rec++;
    end
    cycle_limit = 2 * n_rec + 50;
    exp_pc      = `IFETCH_RESET_PC;
    exp_delay   = 1'b0;

    @(posedge clk);
    @(negedge clk);
    check_flag("bus_req.en in reset", bus_req.en, 1'b0);
    check_flag("predict_result in reset", predict_result, 1'b1);
    repeat (2) @(posedge clk);
    resetn <= 1'b1;  // released after the third edge

    for (int r = 0; r < n_rec; r++)
    begin
      base       = REC_BASE + REC_WORDS * r;
      ctrl       = pat[base];
      stall_mode = pat[base + 1];
      data       = pat[base + 2];
      exp_addr   = pat[base + 3];
      exp_word   = pat[base + 4];
      exp_pr     = pat[base + 5];
      if (stall_mode == 2 || (stall_mode == 1 && ($urandom % 3) == 0))
      begin
        run_stall_cycle();
      end
      @(posedge clk);
      en         <= ctrl[28];
      squashn    <= 1'b1;
      interrupt  <= ctrl[24];
      predict    <= {ctrl[20], ctrl[16], data};
      resolve    <= {ctrl[12], ctrl[8], ctrl[4], ctrl[0], data};
      mem_stall  <= 1'b0;
      mem_ecause <= $urandom;
      @(negedge clk);
      check_addr("bus_req.address", bus_req.address, exp_addr);
      check_instr("instr", instr, exp_word);
      check_addr("pc_out", pc_out, exp_pc + 4);
      check_addr("epc", epc, exp_delay ? exp_pc - 4 : exp_pc);  // branch pc in a slot
      check_addr("ecause", ecause, mem_ecause);
      check_flag("predict_result", predict_result, exp_pr[0]);
      check_flag("bus_req.en", bus_req.en, ctrl[28]);
      check_flag("bus_req.squashn", bus_req.squashn, 1'b1);
      if (ctrl[28])
      begin
        exp_pc    = exp_addr;               // pc takes the fetched address
        exp_delay = branch_word(exp_word);
      end
    end

    @(posedge clk);
    if (error_count == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== dv/ifetch_patterns.txt ====
// words 0x00..0x17: memory image from 0x0400_0000; records start at word 0x18
// record: ctrl stall data addr instr pr
//   ctrl nibbles msb first: en interrupt predict.en uncond rdy load op we
//   stall 0 none, 1 random stall first, 2 one forced stall; data is tgt_pc and resolve.data
@0
24010001 24020002 00221820 10220004 24030003 8c240010 03e00008 ac250014
3c010400 08100010 24040004 14850003 24050005 00a62021 24060006 0c100000
24070007 2408ffff 30a900ff 01095024 240b000b 016c6825 240e000e 000f7880
@18
00000000 0 00000000 04000000 24010001 1 // idle after reset
10000000 0 00000000 04000004 24020002 1
10000000 2 00000000 04000008 00221820 1
10000000 1 00000000 0400000c 10220004 1 // beq
10000000 1 00000000 04000010 24030003 1 // delay slot
11000000 0 00000000 04000020 3c010400 1 // interrupt
10000000 1 00000000 04000024 08100010 1 // j
10000000 1 00000000 04000028 24040004 1
10000010 0 04000014 04000014 8c240010 1 // op load
10000000 1 00000000 04000018 03e00008 1 // jr
10000000 1 00000000 0400001c ac250014 1
10000101 0 04000008 04000008 00221820 0 // load with we
10100000 0 04000040 0400000c 10220004 1 // predict, table not taken
10001100 0 00000000 04000040 24070007 1 // resolve taken, trains entry
10000011 0 04000008 04000008 00221820 0
10100000 0 04000050 04000050 240b000b 1 // predict, table taken
10001001 0 00000000 0400000c 10220004 0 // resolve not taken, rollback
10000000 0 00000000 04000010 24030003 1
10110000 0 04000048 04000048 30a900ff 1 // unconditional
10001000 0 00000000 0400004c 01095024 1
10000000 1 00000000 04000050 240b000b 1
10000000 1 00000000 04000054 016c6825 1
10000000 1 00000000 04000058 240e000e 1
10000000 1 00000000 0400005c 000f7880 1
ffffffff 0 00000000 00000000 00000000 0 // end of records

// ==== project.f ====
+incdir+rtl
rtl/ifetch_pkg.sv
rtl/predict_table.sv
rtl/pc_sequencer.sv
rtl/instr_stage.sv
rtl/ifetch_top.sv
dv/ifetch_tb.sv
